/* Makefile */
# Verilator build and run of the keyboard to LCD testbench

SRCS := $(wildcard *.sv *.svh) filelist.f

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vkbd_lcd_tb: $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module kbd_lcd_tb -f filelist.f

# Fails on a nonzero simulator exit or on the fail message in the log
run: obj_dir/Vkbd_lcd_tb
	./obj_dir/Vkbd_lcd_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi; \
	if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* filelist.f */
+incdir+.
kbd_lcd_pkg.sv
ps2_receiver.sv
lcd_bus_controller.sv
scan_display_sequencer.sv
kbd_lcd_top.sv
tb_clock_gen.sv
kbd_lcd_sva.sv
kbd_lcd_tb.sv

/* kbd_lcd_pkg.sv */
// **************************************************************************
// Shared types for the keyboard to LCD path
// **************************************************************************
package kbd_lcd_pkg;

	typedef logic [7:0] lcd_byte_t;
	typedef logic [3:0] nibble_t;

	// One received PS/2 code with its raw parity bit
	typedef struct packed {
		lcd_byte_t code;
		logic parity_bit;
	} scan_code_t;

	// One write on the LCD bus
	typedef struct packed {
		logic is_data; // Register select, 1 for a character
		lcd_byte_t value;
	} lcd_op_t;

	typedef enum logic [1:0] {
		IDLE,
		SETUP,
		ENABLE,
		EXEC
	} lcd_phase_e;

	typedef enum logic [1:0] {
		INIT,
		WAIT_CODE,
		WRITE
	} seq_state_e;

endpackage

/* kbd_lcd_settings.svh */
// **************************************************************************
// LCD timing is counted in CLK cycles, so scale these to the board clock.
// Every cycle count must be at least 1; the PS/2 synchroniser needs 2 stages
// **************************************************************************
`ifndef KBD_LCD_SETTINGS_SVH
`define KBD_LCD_SETTINGS_SVH

// Byte and rs valid before enable rises
`define LCD_SETUP_CYCLES 2

// Enable pulse width
`define LCD_E_CYCLES 4

`define LCD_EXEC_CYCLES 20 // Ordinary command or data byte

// Clear and home need a much longer wait
`define LCD_CLEAR_CYCLES 80

`define PS2_SYNC_STAGES 2 // Flops per PS/2 line

// DDRAM address of the first character
`define LCD_START_ADDR 8'h44

`endif

/* kbd_lcd_sva.sv */
// **************************************************************************
// Bound into kbd_lcd_top. Checks LCD enable timing, bus hold and handshakes.
// All checks are off while lcdreset is high
// **************************************************************************
`include "kbd_lcd_settings.svh"

module kbd_lcd_sva (
	input logic CLK,
	input logic lcdreset,
	input kbd_lcd_pkg::lcd_op_t op,
	input logic op_valid,
	input logic op_ready,
	input kbd_lcd_pkg::scan_code_t code,
	input logic code_valid,
	input logic code_ready,
	input kbd_lcd_pkg::lcd_byte_t lcd_d,
	input logic lcd_rs,
	input logic lcd_e
);

	localparam logic [7:0] E_CYCLES = 8'(`LCD_E_CYCLES);
	localparam logic [7:0] SETUP_CYCLES = 8'(`LCD_SETUP_CYCLES);

	logic [7:0] e_high_cnt; // Samples with lcd_e high
	logic [7:0] since_hs; // Samples since the last op handshake, 0 before any

	always_ff @(posedge CLK) begin
		if (lcdreset) begin
			e_high_cnt <= '0;
			since_hs <= '0;
		end else begin
			if (lcd_e)
				e_high_cnt <= e_high_cnt + 8'd1;
			else
				e_high_cnt <= '0;
			if (op_valid && op_ready)
				since_hs <= 8'd1;
			else if ((since_hs != 8'd0) && (since_hs != 8'hff))
				since_hs <= since_hs + 8'd1; // Saturates
		end
	end

	e_width: assert property (@(posedge CLK) disable iff (lcdreset)
		$fell(lcd_e) |-> (e_high_cnt == E_CYCLES))
		else $error("lcd_e pulse width differs from the enable cycle count");

	e_bound: assert property (@(posedge CLK) disable iff (lcdreset)
		lcd_e |-> (e_high_cnt < E_CYCLES))
		else $error("lcd_e stayed high past the enable cycle count");

	e_setup: assert property (@(posedge CLK) disable iff (lcdreset)
		$rose(lcd_e) |-> (since_hs > SETUP_CYCLES))
		else $error("lcd_e rose too soon after the op handshake");

	bus_hold_e: assert property (@(posedge CLK) disable iff (lcdreset)
		lcd_e |-> ($stable(lcd_d) && $stable(lcd_rs)))
		else $error("lcd_d or lcd_rs changed while lcd_e was high");

	bus_hold_busy: assert property (@(posedge CLK) disable iff (lcdreset)
		(!op_ready && !$past(op_ready)) |-> ($stable(lcd_d) && $stable(lcd_rs)))
		else $error("lcd_d or lcd_rs changed before the controller was ready");

	op_hold: assert property (@(posedge CLK) disable iff (lcdreset)
		(op_valid && !op_ready) |=> (op_valid && $stable(op)))
		else $error("op changed or op_valid dropped before op_ready");

	code_hold: assert property (@(posedge CLK) disable iff (lcdreset)
		(code_valid && !code_ready) |=> (code_valid && $stable(code)))
		else $error("code changed or code_valid dropped before code_ready");

endmodule

/* kbd_lcd_tb.sv */
// **************************************************************************
// Bit-bangs PS/2 frames and checks each LCD write against the "HH:C:P" rule.
// Bus bytes are taken on the falling edge of lcd_e outside reset
// **************************************************************************
`include "kbd_lcd_settings.svh"

module kbd_lcd_tb;

	localparam int PS2_HALF = 6; // CLK cycles per PS/2 clock phase
	localparam int WAIT_LIMIT = 3000;
	localparam int QUIET_CYCLES = 400;

	logic CLK;
	logic rst_init;
	logic rst_force;
	logic lcdreset;
	logic ps2_clk;
	logic ps2_dat;
	kbd_lcd_pkg::lcd_byte_t lcd_d;
	logic lcd_rs;
	logic lcd_e;

	logic [8:0] bus_q[$]; // {rs, byte} per enable pulse
	logic [31:0] lfsr;
	logic timed_out;
	int tests_run;
	int tests_failed;
	int checks;
	int errors;
	int test_errors;
	string test_name;

	assign lcdreset = rst_init | rst_force;

	tb_clock_gen clk_gen (
		.CLK(CLK),
		.rst(rst_init)
	);

	kbd_lcd_top dut (
		.CLK(CLK),
		.lcdreset(lcdreset),
		.ps2_clk(ps2_clk),
		.ps2_dat(ps2_dat),
		.lcd_d(lcd_d),
		.lcd_rs(lcd_rs),
		.lcd_e(lcd_e)
	);

	bind kbd_lcd_top kbd_lcd_sva u_sva (
		.CLK(CLK),
		.lcdreset(lcdreset),
		.op(op),
		.op_valid(op_valid),
		.op_ready(op_ready),
		.code(code),
		.code_valid(code_valid),
		.code_ready(code_ready),
		.lcd_d(lcd_d),
		.lcd_rs(lcd_rs),
		.lcd_e(lcd_e)
	);

	always @(negedge lcd_e) begin
		if (!lcdreset)
			bus_q.push_back({lcd_rs, lcd_d}); // Display latches here
	end

	// Taps 32, 22, 2, 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] take_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[6:0], lfsr_bit()};
		return v;
	endfunction

	function automatic kbd_lcd_pkg::lcd_byte_t hex_char(input kbd_lcd_pkg::nibble_t n);
		string digits;
		digits = "0123456789ABCDEF";
		return digits[n];
	endfunction

	// Odd parity unless corrupted
	function automatic kbd_lcd_pkg::scan_code_t with_parity(input kbd_lcd_pkg::lcd_byte_t c,
		input logic corrupt);
		kbd_lcd_pkg::scan_code_t sc;
		sc.code = c;
		sc.parity_bit = ~(^c) ^ corrupt;
		return sc;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge CLK);
		#1;
	endtask

	task automatic send_frame(input kbd_lcd_pkg::scan_code_t sc, input logic stop_bit);
		logic [10:0] frame;
		frame = {stop_bit, sc.parity_bit, sc.code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			ps2_dat = frame[i]; // Changes while ps2_clk is high
			wait_cycles(PS2_HALF);
			ps2_clk = 1'b0;
			wait_cycles(PS2_HALF);
			ps2_clk = 1'b1;
		end
		wait_cycles(PS2_HALF);
		ps2_dat = 1'b1;
	endtask

	task automatic wait_writes(input int n);
		int t;
		t = 0;
		while (!timed_out && (bus_q.size() < n) && (t < WAIT_LIMIT)) begin
			wait_cycles(1);
			t++;
		end
		if (!timed_out && (bus_q.size() < n)) begin
			$display("Timeout: no LCD write within %0d cycles in test %s",
				WAIT_LIMIT, test_name);
			timed_out = 1'b1;
			errors++;
		end
	endtask

	task automatic wait_e_high();
		int t;
		t = 0;
		while (!timed_out && (lcd_e !== 1'b1) && (t < WAIT_LIMIT)) begin
			wait_cycles(1);
			t++;
		end
		if (!timed_out && (lcd_e !== 1'b1)) begin
			$display("Timeout: lcd_e did not rise within %0d cycles in test %s",
				WAIT_LIMIT, test_name);
			timed_out = 1'b1;
			errors++;
		end
	endtask

	task automatic expect_write(input logic exp_rs, input kbd_lcd_pkg::lcd_byte_t exp_d);
		logic [8:0] got;
		wait_writes(1);
		if (!timed_out) begin
			got = bus_q.pop_front();
			checks++;
			assert (got[8] === exp_rs) else begin
				$display("FAIL lcd_rs expected %h got %h", exp_rs, got[8]);
				errors++;
			end
			assert (got[7:0] === exp_d) else begin
				$display("FAIL lcd_d expected %h got %h", exp_d, got[7:0]);
				errors++;
			end
		end
	endtask

	task automatic expect_init();
		expect_write(1'b0, 8'h38);
		expect_write(1'b0, 8'h0c);
		expect_write(1'b0, 8'h01);
		expect_write(1'b0, 8'h06);
	endtask

	task automatic expect_display(input kbd_lcd_pkg::scan_code_t sc, input logic corrupt);
		expect_write(1'b0, 8'h80 + `LCD_START_ADDR);
		expect_write(1'b1, hex_char(sc.code[7:4]));
		expect_write(1'b1, hex_char(sc.code[3:0]));
		expect_write(1'b1, 8'h3a); // ':'
		expect_write(1'b1, corrupt ? 8'h30 : 8'h31); // '1' only for a good frame
		expect_write(1'b1, 8'h3a);
		expect_write(1'b1, sc.parity_bit ? 8'h31 : 8'h30);
	endtask

	task automatic check_e_low(input int n);
		repeat (n) begin
			wait_cycles(1);
			checks++;
			assert (lcd_e === 1'b0) else begin
				$display("FAIL lcd_e expected 0 got %h", lcd_e);
				errors++;
			end
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors == test_errors) begin
			$display("test %0d %s: ok", tests_run, test_name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, test_name, errors - test_errors);
		end
	endtask

	initial begin
		kbd_lcd_pkg::scan_code_t sc;
		kbd_lcd_pkg::scan_code_t sc2;
		kbd_lcd_pkg::lcd_byte_t code_byte;
		logic corrupt;
		logic corrupt2;
		logic [3:0] k_hi;
		logic [3:0] k_lo;
		int t;
		rst_force = 1'b0;
		ps2_clk = 1'b1; // PS/2 lines idle high
		ps2_dat = 1'b1;
		lfsr = 32'hbf48bb97;
		timed_out = 1'b0;
		tests_run = 0;
		tests_failed = 0;
		checks = 0;
		errors = 0;

		begin_test("reset_init");
		check_e_low(4);
		expect_init();
		end_test();

		begin_test("odd_parity");
		sc = with_parity(take_bits(8), 1'b0);
		send_frame(sc, 1'b1);
		expect_display(sc, 1'b0);
		end_test();

		begin_test("bad_parity");
		sc = with_parity(take_bits(8), 1'b1);
		send_frame(sc, 1'b1);
		expect_display(sc, 1'b1);
		end_test();

		// XOR with a fixed nibble still visits all sixteen digits
		begin_test("lfsr_codes");
		k_hi = 4'(take_bits(4));
		k_lo = 4'(take_bits(4));
		for (int i = 0; i < 20; i++) begin
			if (i < 16)
				code_byte = {i[3:0] ^ k_hi, i[3:0] ^ k_lo};
			else
				code_byte = take_bits(8);
			corrupt = lfsr_bit();
			sc = with_parity(code_byte, corrupt);
			send_frame(sc, 1'b1);
			expect_display(sc, corrupt);
		end
		end_test();

		begin_test("back_to_back");
		corrupt = lfsr_bit();
		sc = with_parity(take_bits(8), corrupt);
		corrupt2 = lfsr_bit();
		sc2 = with_parity(take_bits(8), corrupt2);
		send_frame(sc, 1'b1);
		send_frame(sc2, 1'b1); // Ends while the first line is still written
		expect_display(sc, corrupt);
		expect_display(sc2, corrupt2);
		end_test();

		begin_test("bad_stop");
		sc = with_parity(take_bits(8), 1'b0);
		send_frame(sc, 1'b0);
		t = 0;
		while (!timed_out && (bus_q.size() == 0) && (t < QUIET_CYCLES)) begin
			wait_cycles(1);
			t++;
		end
		checks++;
		assert (bus_q.size() == 0) else begin
			$display("An LCD write followed a frame with a bad stop bit");
			errors++;
			bus_q.delete();
		end
		sc = with_parity(take_bits(8), 1'b0);
		send_frame(sc, 1'b1);
		expect_display(sc, 1'b0);
		end_test();

		begin_test("reset_mid_write");
		sc = with_parity(take_bits(8), 1'b0);
		send_frame(sc, 1'b1);
		wait_writes(2);
		wait_e_high(); // Third write of the line is on the bus
		rst_force = 1'b1;
		wait_cycles(1);
		check_e_low(4);
		bus_q.delete(); // Drop the cut-off display line
		rst_force = 1'b0;
		expect_init();
		corrupt = lfsr_bit();
		sc = with_parity(take_bits(8), corrupt);
		send_frame(sc, 1'b1);
		expect_display(sc, corrupt);
		end_test();

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if ((errors == 0) && !timed_out)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* kbd_lcd_top.sv */
// **************************************************************************
// LCD read/write line is tied low on the board and is not driven here
// **************************************************************************
module kbd_lcd_top (
	input logic CLK,
	input logic lcdreset,
	input logic ps2_clk,
	input logic ps2_dat,
	output kbd_lcd_pkg::lcd_byte_t lcd_d,
	output logic lcd_rs,
	output logic lcd_e
);

	kbd_lcd_pkg::scan_code_t code;
	logic code_valid;
	logic code_ready;
	kbd_lcd_pkg::lcd_op_t op;
	logic op_valid;
	logic op_ready;

	ps2_receiver u_receiver (
		.CLK(CLK),
		.lcdreset(lcdreset),
		.ps2_clk(ps2_clk),
		.ps2_dat(ps2_dat),
		.code_ready(code_ready),
		.code(code),
		.code_valid(code_valid)
	);

	scan_display_sequencer u_sequencer (
		.CLK(CLK),
		.lcdreset(lcdreset),
		.code(code),
		.code_valid(code_valid),
		.op_ready(op_ready),
		.code_ready(code_ready),
		.op(op),
		.op_valid(op_valid)
	);

	lcd_bus_controller u_lcd_ctrl (
		.CLK(CLK),
		.lcdreset(lcdreset),
		.op(op),
		.op_valid(op_valid),
		.op_ready(op_ready),
		.lcd_d(lcd_d),
		.lcd_rs(lcd_rs),
		.lcd_e(lcd_e)
	);

endmodule

/* lcd_bus_controller.sv */
// **************************************************************************
// Write-only HD44780 bus, the busy flag is never read.
// Byte and rs are held from acceptance until op_ready returns
// **************************************************************************
`include "kbd_lcd_settings.svh"

module lcd_bus_controller (
	input logic CLK,
	input logic lcdreset,
	input kbd_lcd_pkg::lcd_op_t op,
	input logic op_valid,
	output logic op_ready,
	output kbd_lcd_pkg::lcd_byte_t lcd_d,
	output logic lcd_rs,
	output logic lcd_e
);

	localparam int CNT_W = 16;

	kbd_lcd_pkg::lcd_phase_e phase;
	logic [CNT_W-1:0] cnt;
	logic cnt_done;
	logic long_wait;

	assign op_ready = (phase == kbd_lcd_pkg::IDLE);
	assign cnt_done = (cnt == '0);

	// Clear and home commands
	assign long_wait = !lcd_rs && ((lcd_d == 8'h01) || (lcd_d == 8'h02));

	always_ff @(posedge CLK) begin
		if (lcdreset) begin
			phase <= kbd_lcd_pkg::IDLE;
			cnt <= '0;
			lcd_e <= 1'b0;
			lcd_d <= '0;
			lcd_rs <= 1'b0;
		end else begin
			case (phase)
				kbd_lcd_pkg::IDLE: begin
					if (op_valid) begin
						lcd_d <= op.value; // Onto the bus at once
						lcd_rs <= op.is_data;
						cnt <= CNT_W'(`LCD_SETUP_CYCLES - 1);
						phase <= kbd_lcd_pkg::SETUP;
					end
				end
				kbd_lcd_pkg::SETUP: begin
					if (cnt_done) begin
						lcd_e <= 1'b1;
						cnt <= CNT_W'(`LCD_E_CYCLES - 1);
						phase <= kbd_lcd_pkg::ENABLE;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				kbd_lcd_pkg::ENABLE: begin
					if (cnt_done) begin
						lcd_e <= 1'b0; // Display latches on this edge
						if (long_wait)
							cnt <= CNT_W'(`LCD_CLEAR_CYCLES - 1);
						else
							cnt <= CNT_W'(`LCD_EXEC_CYCLES - 1);
						phase <= kbd_lcd_pkg::EXEC;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				kbd_lcd_pkg::EXEC: begin
					if (cnt_done)
						phase <= kbd_lcd_pkg::IDLE;
					else
						cnt <= cnt - 1'b1;
				end
				default: phase <= kbd_lcd_pkg::IDLE;
			endcase
		end
	end

endmodule

/* ps2_receiver.sv */
// **************************************************************************
// Device-to-host frames only. No idle timeout, so alignment is set by reset.
// code_valid rises PS2_SYNC_STAGES+1 clocks after the stop bit's falling edge
// **************************************************************************
`include "kbd_lcd_settings.svh"

module ps2_receiver (
	input logic CLK,
	input logic lcdreset,
	input logic ps2_clk,
	input logic ps2_dat,
	input logic code_ready,
	output kbd_lcd_pkg::scan_code_t code,
	output logic code_valid
);

	localparam int SYNC_N = `PS2_SYNC_STAGES;

	logic [SYNC_N-1:0] clk_sync;
	logic [SYNC_N-1:0] dat_sync;
	logic clk_prev;
	logic clk_fall;
	logic dat_bit;
	logic [3:0] bit_cnt;
	logic [9:0] shift; // Start, data, parity
	logic frame_ok;
	logic load_code;

	assign clk_fall = clk_prev & ~clk_sync[SYNC_N-1];
	assign dat_bit = dat_sync[SYNC_N-1];

	// Stop bit is on the line at the eleventh falling edge
	assign frame_ok = clk_fall && (bit_cnt == 4'd10) && !shift[0] && dat_bit;

	// A held code blocks the new one, the keyboard cannot wait
	assign load_code = frame_ok && (!code_valid || code_ready);

	always_ff @(posedge CLK) begin
		if (lcdreset) begin
			clk_sync <= '1; // Idle lines are high
			dat_sync <= '1;
			clk_prev <= 1'b1;
			bit_cnt <= '0;
			code_valid <= 1'b0;
		end else begin
			clk_sync <= {clk_sync[SYNC_N-2:0], ps2_clk};
			dat_sync <= {dat_sync[SYNC_N-2:0], ps2_dat};
			clk_prev <= clk_sync[SYNC_N-1];
			if (clk_fall) begin
				if (bit_cnt == 4'd10)
					bit_cnt <= '0;
				else
					bit_cnt <= bit_cnt + 4'd1;
			end
			if (load_code)
				code_valid <= 1'b1;
			else if (code_ready)
				code_valid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (clk_fall && (bit_cnt != 4'd10))
			shift <= {dat_bit, shift[9:1]}; // LSB first
		if (load_code) begin
			code.code <= shift[8:1];
			code.parity_bit <= shift[9];
		end
	end

endmodule

/* scan_display_sequencer.sv */
// **************************************************************************
// Shows each code as "HH:C:P" from LCD_START_ADDR. One cycle gap between ops.
// Extended E0/F0 codes are shown as plain bytes
// **************************************************************************
`include "kbd_lcd_settings.svh"

module scan_display_sequencer (
	input logic CLK,
	input logic lcdreset,
	input kbd_lcd_pkg::scan_code_t code,
	input logic code_valid,
	input logic op_ready,
	output logic code_ready,
	output kbd_lcd_pkg::lcd_op_t op,
	output logic op_valid
);

	localparam logic [2:0] INIT_LAST = 3'd3;
	localparam logic [2:0] WRITE_LAST = 3'd6;

	kbd_lcd_pkg::seq_state_e state;
	logic [2:0] step;
	kbd_lcd_pkg::scan_code_t held;
	logic check_digit;
	kbd_lcd_pkg::lcd_op_t next_op;

	function automatic kbd_lcd_pkg::lcd_byte_t hex_ascii(input kbd_lcd_pkg::nibble_t n);
		kbd_lcd_pkg::nibble_t above_nine;
		above_nine = n - 4'd10;
		if (n < 4'd10)
			return 8'h30 + {4'h0, n};
		else
			return 8'h41 + {4'h0, above_nine};
	endfunction

	assign code_ready = (state == kbd_lcd_pkg::WAIT_CODE);

	always_comb begin
		next_op.is_data = 1'b1;
		next_op.value = 8'h3a; // ':'
		if (state == kbd_lcd_pkg::INIT) begin
			next_op.is_data = 1'b0;
			case (step)
				3'd0: next_op.value = 8'h38; // 8-bit bus, two lines
				3'd1: next_op.value = 8'h0c; // Display on, no cursor
				3'd2: next_op.value = 8'h01;
				default: next_op.value = 8'h06; // Increment, no shift
			endcase
		end else begin
			case (step)
				3'd0: begin
					next_op.is_data = 1'b0;
					next_op.value = 8'h80 + `LCD_START_ADDR; // Set DDRAM address
				end
				3'd1: next_op.value = hex_ascii(held.code[7:4]);
				3'd2: next_op.value = hex_ascii(held.code[3:0]);
				3'd4: next_op.value = {7'b0011000, check_digit};
				3'd6: next_op.value = {7'b0011000, held.parity_bit};
				default: next_op.value = 8'h3a;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (lcdreset) begin
			state <= kbd_lcd_pkg::INIT;
			step <= '0;
			op_valid <= 1'b0;
		end else begin
			case (state)
				kbd_lcd_pkg::WAIT_CODE: begin
					if (code_valid) begin
						state <= kbd_lcd_pkg::WRITE;
						step <= '0;
					end
				end
				kbd_lcd_pkg::INIT, kbd_lcd_pkg::WRITE: begin
					if (!op_valid) begin
						op_valid <= 1'b1;
					end else if (op_ready) begin
						op_valid <= 1'b0;
						if ((state == kbd_lcd_pkg::INIT) && (step == INIT_LAST)) begin
							state <= kbd_lcd_pkg::WAIT_CODE;
							step <= '0;
						end else if ((state == kbd_lcd_pkg::WRITE) && (step == WRITE_LAST)) begin
							state <= kbd_lcd_pkg::WAIT_CODE;
							step <= '0;
						end else begin
							step <= step + 3'd1;
						end
					end
				end
				default: state <= kbd_lcd_pkg::INIT;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (code_valid && code_ready) begin
			held <= code;
			check_digit <= ^code; // 1 when odd parity holds
		end
		if (!op_valid)
			op <= next_op; // Loaded with op_valid, held until accepted
	end

endmodule

/* tb_clock_gen.sv */
// **************************************************************************
// Clock of period 4, reset high until 1 unit after the fourth rising edge
// **************************************************************************
module tb_clock_gen (
	output logic CLK,
	output logic rst
);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	initial begin
		rst = 1'b1;
		repeat (4) @(posedge CLK);
		#1 rst = 1'b0; // Released clear of the edge
	end

endmodule
